//--- build.f
spi_pkg.sv
spi_clgen.sv
spi_shift.sv
spi_top.sv
spi_xip_seq.sv
spi_top_apb.sv
spi_flash_model.sv
spi_top_apb_checker.sv
tb_spi_top_apb.sv

//--- Bender.yml
package:
  name: spi_xip_apb

sources:
  - spi_pkg.sv
  - spi_clgen.sv
  - spi_shift.sv
  - spi_top.sv
  - spi_xip_seq.sv
  - spi_top_apb.sv
  - target: test
    files:
      - spi_flash_model.sv
      - spi_top_apb_checker.sv
      - tb_spi_top_apb.sv

//--- tb_spi_top_apb.sv
`timescale 1ns/10ps

module tb_spi_top_apb;
  import spi_pkg::*;

  // Wait limits, in clock cycles or polls
  localparam int APB_TIMEOUT = 4000;
  localparam int POLL_LIMIT  = 200;
  localparam int IRQ_TIMEOUT = 2000;

  logic       clock;
  logic       reset;
  word_t      paddr;
  logic       psel;
  logic       penable;
  logic [2:0] pprot;
  logic       pwrite;
  word_t      pwdata;
  strb_t      pstrb;
  logic       pready;
  word_t      prdata;
  logic       pslverr;
  logic       sck;
  ss_t        ss_n;
  logic       mosi;
  logic       miso;
  logic       flash_miso;
  logic       irq;

  logic [31:0] rnd;
  int          checks;
  int          errors;
  int          tests;
  int          checks_mark;
  int          errors_mark;
  // Mixed byte-lane patterns for the register test
  strb_t       lanes [5] = '{4'hF, 4'h2, 4'h1, 4'h6, 4'hA};

  // Flash on select 0, loopback otherwise
  assign miso = ss_n[0] ? mosi : flash_miso;

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  spi_top_apb uut (
    .clock     (clock),
    .reset     (reset),
    .paddr_i   (paddr),
    .psel_i    (psel),
    .penable_i (penable),
    .pprot_i   (pprot),
    .pwrite_i  (pwrite),
    .pwdata_i  (pwdata),
    .pstrb_i   (pstrb),
    .pready_o  (pready),
    .prdata_o  (prdata),
    .pslverr_o (pslverr),
    .sck_o     (sck),
    .ss_o      (ss_n),
    .mosi_o    (mosi),
    .miso_i    (miso),
    .irq_o     (irq)
  );

  spi_flash_model u_flash (
    .sck_i  (sck),
    .ss_n_i (ss_n[0]),
    .mosi_i (mosi),
    .miso_o (flash_miso)
  );

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Word stored at flash byte address a
  function automatic word_t flash_word(input logic [23:0] a);
    return {8'h00, a[23:2], 2'b00} ^ 32'hA5A5_5A5A;
  endfunction

  // Old value with the enabled byte lanes replaced
  function automatic word_t merge_lanes(input word_t prev, input word_t data, input strb_t strb);
    word_t res;
    int    b;
    res = prev;
    for (b = 0; b < 4; b++) begin
      if (strb[b]) begin
        res[8*b +: 8] = data[8*b +: 8];
      end
    end
    return res;
  endfunction

  task automatic check_value(input string name, input word_t got, input word_t exp);
    checks++;
    assert (got === exp) else begin
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic report_timeout(input string what);
    errors++;
    $display("Timed out waiting for %s", what);
  endtask

  // One APB transfer, counts negedges from the access phase until pready
  task automatic apb_transfer(input word_t addr, input logic write, input word_t wdata,
                              input strb_t strb, output word_t rdata, output logic slverr,
                              output int waits);
    logic seen;
    @(posedge clock);
    paddr   <= addr;
    pwrite  <= write;
    pwdata  <= wdata;
    pstrb   <= write ? strb : 4'h0;
    psel    <= 1'b1;
    penable <= 1'b0;
    @(posedge clock);
    penable <= 1'b1;
    seen   = 1'b0;
    waits  = 0;
    rdata  = '0;
    slverr = 1'b0;
    while (!seen && waits < APB_TIMEOUT) begin
      @(negedge clock);
      waits++;
      if (pready) begin
        seen   = 1'b1;
        rdata  = prdata;
        slverr = pslverr;
      end
    end
    if (!seen) begin
      report_timeout($sformatf("pready_o at address %h", addr));
    end
    @(posedge clock);
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
  endtask

  // Register window access, zero error and one wait state expected
  task automatic reg_access(input wb_addr_t offset, input logic write, input word_t wdata,
                            input strb_t strb, output word_t rdata);
    logic err;
    int   waits;
    apb_transfer(SPI_MASTER_BASE + word_t'(offset), write, wdata, strb, rdata, err, waits);
    check_value("pready_o latency", word_t'(waits), 32'd2);
    check_value("pslverr_o", word_t'(err), '0);
  endtask

  task automatic reg_write(input wb_addr_t offset, input word_t wdata, input strb_t strb);
    word_t unused;
    reg_access(offset, 1'b1, wdata, strb, unused);
  endtask

  task automatic reg_read(input wb_addr_t offset, output word_t rdata);
    reg_access(offset, 1'b0, '0, 4'h0, rdata);
  endtask

  task automatic wait_not_busy();
    word_t rd;
    int    polls;
    logic  busy;
    busy  = 1'b1;
    polls = 0;
    while (busy && polls < POLL_LIMIT) begin
      reg_read(REG_CTRL, rd);
      busy = rd[CTRL_GO_BIT];
      polls++;
    end
    if (busy) begin
      report_timeout("the CTRL go bit to clear");
    end
  endtask

  task automatic end_test(input string name);
    tests++;
    $display("test %0d %s: %0d checks, %0d errors", tests, name,
             checks - checks_mark, errors - errors_mark);
    checks_mark = checks;
    errors_mark = errors;
  endtask

  initial begin
    word_t div_exp;
    word_t ss_exp;
    word_t tx;
    word_t rd;
    word_t addr;
    logic  err;
    int    waits;
    int    cycles;
    int    total;
    checks      = 0;
    errors      = 0;
    tests       = 0;
    checks_mark = 0;
    errors_mark = 0;
    rnd         = 32'h1b6a_ca11;
    div_exp     = '0;
    ss_exp      = '0;
    reset   <= 1'b1;
    paddr   <= '0;
    psel    <= 1'b0;
    penable <= 1'b0;
    pprot   <= 3'b000;
    pwrite  <= 1'b0;
    pwdata  <= '0;
    pstrb   <= 4'h0;
    repeat (4) @(posedge clock);
    reset <= 1'b0;

    // Idle outputs after reset
    @(negedge clock);
    check_value("pready_o", word_t'(pready), '0);
    check_value("pslverr_o", word_t'(pslverr), '0);
    check_value("irq_o", word_t'(irq), '0);
    check_value("sck_o", word_t'(sck), '0);
    check_value("ss_o", word_t'(ss_n), 32'h0000_00FF);
    end_test("reset");

    // DIVIDER holds 16 bits, SS holds 8
    for (int i = 0; i < 5; i++) begin
      rnd = lcg_step(rnd);
      reg_write(REG_DIVIDER, rnd, lanes[i]);
      div_exp = merge_lanes(div_exp, rnd, lanes[i]) & 32'h0000_FFFF;
      reg_read(REG_DIVIDER, rd);
      check_value("DIVIDER", rd, div_exp);
      rnd = lcg_step(rnd);
      reg_write(REG_SS, rnd, lanes[i]);
      ss_exp = merge_lanes(ss_exp, rnd, lanes[i]) & 32'h0000_00FF;
      reg_read(REG_SS, rd);
      check_value("SS", rd, ss_exp);
    end
    end_test("register lanes");

    // Select 1 keeps the flash idle and mosi looped back
    reg_write(REG_DIVIDER, 32'd2, 4'hF);
    reg_write(REG_SS, 32'h0000_0002, 4'hF);
    rnd = lcg_step(rnd);
    tx  = rnd;
    reg_write(REG_TX0, tx, 4'hF);
    reg_write(REG_CTRL, (32'd1 << CTRL_GO_BIT) | 32'd8, 4'hF);
    wait_not_busy();
    reg_read(REG_RX0, rd);
    check_value("RX0[7:0]", rd & 32'hFF, tx & 32'hFF);
    end_test("loopback");

    // Flash window reads through the sequencer
    for (int i = 0; i < 8; i++) begin
      rnd  = lcg_step(rnd);
      addr = FLASH_ADDR_START | (rnd & 32'h0FFF_FFFF);
      apb_transfer(addr, 1'b0, '0, 4'h0, rd, err, waits);
      check_value("prdata_o", rd, flash_word(addr[23:0]));
      check_value("pslverr_o", word_t'(err), '0);
      @(negedge clock);
      check_value("ss_o[0]", word_t'(ss_n[0]), 32'd1);
    end
    end_test("xip reads");

    // Completion interrupt, cleared by the next access
    reg_write(REG_SS, 32'h0000_0002, 4'hF);
    rnd = lcg_step(rnd);
    reg_write(REG_TX0, rnd, 4'hF);
    reg_write(REG_CTRL, (32'd1 << CTRL_IE_BIT) | (32'd1 << CTRL_GO_BIT) | 32'd8, 4'hF);
    cycles = 0;
    do begin
      @(negedge clock);
      cycles++;
    end while (!irq && cycles < IRQ_TIMEOUT);
    if (!irq) begin
      report_timeout("irq_o to rise");
    end
    check_value("irq_o", word_t'(irq), 32'd1);
    reg_read(REG_CTRL, rd);
    check_value("CTRL go", word_t'(rd[CTRL_GO_BIT]), '0);
    check_value("CTRL ie", word_t'(rd[CTRL_IE_BIT]), 32'd1);
    @(negedge clock);
    check_value("irq_o", word_t'(irq), '0);
    reg_write(REG_CTRL, '0, 4'hF);
    end_test("interrupt");

    // Unmapped read answers in the access-phase cycle
    apb_transfer(32'h2000_0000, 1'b0, '0, 4'h0, rd, err, waits);
    check_value("pready_o latency", word_t'(waits), 32'd1);
    check_value("pslverr_o", word_t'(err), 32'd1);
    // Same for a flash write
    apb_transfer(FLASH_ADDR_START + 32'h40, 1'b1, 32'hDEAD_BEEF, 4'hF, rd, err, waits);
    check_value("pready_o latency", word_t'(waits), 32'd1);
    check_value("pslverr_o", word_t'(err), 32'd1);
    end_test("error response");

    total = errors + int'(uut.u_checker.fail_cnt);
    $display("tests %0d, checks %0d, errors %0d, assertion failures %0d",
             tests, checks, errors, uut.u_checker.fail_cnt);
    if (total == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

//--- spi_top_apb_checker.sv
`timescale 1ns/10ps

module spi_top_apb_checker (
  input logic         clock,
  input logic         reset,
  input logic         psel_i,
  input logic         penable_i,
  input logic         pready_i,
  input logic         pslverr_i,
  input logic         sck_i,
  input spi_pkg::ss_t ss_i,
  input logic         irq_i
);

  // Failed assertions so far, read by the testbench at the end
  int unsigned fail_cnt = 0;

  // Ready only inside an access phase
  ready_in_access: assert property (@(posedge clock) disable iff (reset)
    pready_i |-> (psel_i && penable_i))
    else begin
      fail_cnt++;
      $error("pready_o high outside an APB access phase");
    end

  // Error response always completes the transfer
  err_with_ready: assert property (@(posedge clock) disable iff (reset)
    pslverr_i |-> pready_i)
    else begin
      fail_cnt++;
      $error("pslverr_o high without pready_o");
    end

  // No serial clock with every select released
  sck_parked: assert property (@(posedge clock) disable iff (reset)
    (&ss_i) |-> !sck_i)
    else begin
      fail_cnt++;
      $error("sck_o toggling while all ss_o are high");
    end

  // Interrupt held low in reset
  irq_reset: assert property (@(posedge clock)
    reset |-> !irq_i)
    else begin
      fail_cnt++;
      $error("irq_o high during reset");
    end

endmodule

bind spi_top_apb spi_top_apb_checker u_checker (
  .clock     (clock),
  .reset     (reset),
  .psel_i    (psel_i),
  .penable_i (penable_i),
  .pready_i  (pready_o),
  .pslverr_i (pslverr_o),
  .sck_i     (sck_o),
  .ss_i      (ss_o),
  .irq_i     (irq_o)
);

//--- spi_flash_model.sv
`timescale 1ns/10ps

module spi_flash_model (
  input  logic sck_i,
  input  logic ss_n_i,
  input  logic mosi_i,
  output logic miso_o
);
  import spi_pkg::*;

  // Rising edges seen since select
  int          bit_cnt;
  // Opcode and address as received
  logic [31:0] cmd;
  // Read data for the received address
  word_t       rd_word;

  initial begin
    bit_cnt = 0;
    cmd     = '0;
    rd_word = '0;
    miso_o  = 1'b0;
  end

  // Every select starts a new command
  always @(negedge ss_n_i) begin
    bit_cnt = 0;
    cmd     = '0;
    miso_o  <= 1'b0;
  end

  // Command bits sampled on the rising edge
  always @(posedge sck_i) begin
    if (!ss_n_i) begin
      if (bit_cnt < 32) begin
        cmd = {cmd[30:0], mosi_i};
      end
      bit_cnt = bit_cnt + 1;
      // Opcode plus 24-bit address complete
      if (bit_cnt == 32) begin
        if (cmd[31:24] == FLASH_READ_OP) begin
          rd_word = {8'h00, cmd[23:2], 2'b00} ^ 32'hA5A5_5A5A;
        end else begin
          rd_word = '0;
        end
      end
    end
  end

  // Data out on the falling edge, MSB first
  always @(negedge sck_i) begin
    if (!ss_n_i && bit_cnt >= 32 && bit_cnt < 64) begin
      miso_o <= rd_word[63 - bit_cnt];
    end
  end

endmodule

//--- spi_top_apb.sv
`timescale 1ns/10ps

module spi_top_apb (
  input  logic           clock,
  input  logic           reset,
  input  spi_pkg::word_t paddr_i,
  input  logic           psel_i,
  input  logic           penable_i,
  input  logic [2:0]     pprot_i,
  input  logic           pwrite_i,
  input  spi_pkg::word_t pwdata_i,
  input  spi_pkg::strb_t pstrb_i,
  output logic           pready_o,
  output spi_pkg::word_t prdata_o,
  output logic           pslverr_o,
  output logic           sck_o,
  output spi_pkg::ss_t   ss_o,
  output logic           mosi_o,
  input  logic           miso_i,
  output logic           irq_o
);
  import spi_pkg::*;

  logic     in_flash;
  logic     in_regs;
  logic     access;
  logic     bad;
  logic     xip_start;
  wb_addr_t wb_adr;
  word_t    wb_dat_w;
  strb_t    wb_sel;
  logic     wb_we;
  logic     wb_stb;
  logic     wb_cyc;
  word_t    wb_dat_r;
  logic     wb_ack;
  logic     wb_err;
  wb_addr_t xip_adr;
  word_t    xip_dat;
  strb_t    xip_sel;
  logic     xip_we;
  logic     xip_stb;
  logic     xip_done;
  word_t    xip_rdata;

  // Window decode, pprot_i has no effect on this slave
  assign in_flash = (paddr_i >= FLASH_ADDR_START) && (paddr_i <= FLASH_ADDR_END);
  assign in_regs  = (paddr_i >= SPI_MASTER_BASE) && (paddr_i <= SPI_MASTER_END);
  assign access   = psel_i && penable_i;
  // Unmapped or flash write, answered at once
  assign bad       = access && (!(in_flash || in_regs) || (in_flash && pwrite_i));
  assign xip_start = access && in_flash && !pwrite_i;

  // Core bus owner
  always_comb begin
    if (in_flash) begin
      wb_adr   = xip_adr;
      wb_dat_w = xip_dat;
      wb_sel   = xip_sel;
      wb_we    = xip_we;
      wb_stb   = xip_stb;
      wb_cyc   = xip_stb;
    end else begin
      wb_adr   = paddr_i[4:0];
      wb_dat_w = pwdata_i;
      wb_sel   = pstrb_i;
      wb_we    = pwrite_i;
      // Only the register window reaches the core
      wb_stb   = psel_i && in_regs;
      wb_cyc   = penable_i;
    end
  end

  // APB response
  always_comb begin
    pready_o  = 1'b0;
    pslverr_o = 1'b0;
    prdata_o  = wb_dat_r;
    if (bad) begin
      pready_o  = 1'b1;
      pslverr_o = 1'b1;
    end else if (in_flash) begin
      pready_o = access && xip_done;
      prdata_o = xip_rdata;
    end else begin
      pready_o  = access && wb_ack;
      pslverr_o = access && wb_err;
    end
  end

  spi_xip_seq u_xip_seq (
    .clock        (clock),
    .reset        (reset),
    .start_i      (xip_start),
    .flash_addr_i (paddr_i[23:0]),
    .wb_ack_i     (wb_ack),
    .wb_dat_i     (wb_dat_r),
    .xip_adr_o    (xip_adr),
    .xip_dat_o    (xip_dat),
    .xip_sel_o    (xip_sel),
    .xip_we_o     (xip_we),
    .xip_stb_o    (xip_stb),
    .done_o       (xip_done),
    .rdata_o      (xip_rdata)
  );

  spi_top u_spi_top (
    .clock      (clock),
    .reset      (reset),
    .wb_adr_i   (wb_adr),
    .wb_dat_i   (wb_dat_w),
    .wb_sel_i   (wb_sel),
    .wb_we_i    (wb_we),
    .wb_stb_i   (wb_stb),
    .wb_cyc_i   (wb_cyc),
    .wb_dat_o   (wb_dat_r),
    .wb_ack_o   (wb_ack),
    .wb_err_o   (wb_err),
    .wb_int_o   (irq_o),
    .ss_pad_o   (ss_o),
    .sclk_pad_o (sck_o),
    .mosi_pad_o (mosi_o),
    .miso_pad_i (miso_i)
  );

endmodule

//--- spi_xip_seq.sv
`timescale 1ns/10ps

module spi_xip_seq (
  input  logic              clock,
  input  logic              reset,
  input  logic              start_i,
  input  logic [23:0]       flash_addr_i,
  input  logic              wb_ack_i,
  input  spi_pkg::word_t    wb_dat_i,
  output spi_pkg::wb_addr_t xip_adr_o,
  output spi_pkg::word_t    xip_dat_o,
  output spi_pkg::strb_t    xip_sel_o,
  output logic              xip_we_o,
  output logic              xip_stb_o,
  output logic              done_o,
  output spi_pkg::word_t    rdata_o
);
  import spi_pkg::*;

  xip_state_t  state;
  xip_state_t  state_next;
  // Flash byte address of the read in flight
  logic [23:0] addr_q;

  // Strobe held through each state while the core acks once per access
  assign xip_stb_o = (state != XIP_IDLE);
  // Whole words only
  assign xip_sel_o = '1;

  // Access per state and next state
  always_comb begin
    xip_adr_o  = REG_CTRL;
    xip_dat_o  = '0;
    xip_we_o   = 1'b1;
    state_next = state;
    case (state)
      XIP_IDLE: begin
        xip_we_o = 1'b0;
        // Done cycle still belongs to the finished APB access
        if (start_i && !done_o) begin
          state_next = XIP_CMD;
        end
      end
      XIP_CMD: begin
        // Opcode and address fill TX1 and go out first
        xip_adr_o = REG_TX1;
        xip_dat_o = {FLASH_READ_OP, addr_q};
        if (wb_ack_i) begin
          state_next = XIP_DIV;
        end
      end
      XIP_DIV: begin
        xip_adr_o = REG_DIVIDER;
        xip_dat_o = word_t'(XIP_DIVIDER);
        if (wb_ack_i) begin
          state_next = XIP_SS;
        end
      end
      XIP_SS: begin
        // Flash sits on select 0
        xip_adr_o = REG_SS;
        xip_dat_o = word_t'(1);
        if (wb_ack_i) begin
          state_next = XIP_GO;
        end
      end
      XIP_GO: begin
        // Go plus the full 64-bit length
        xip_dat_o = word_t'(XIP_CHAR_LEN) | (word_t'(1) << CTRL_GO_BIT);
        if (wb_ack_i) begin
          state_next = XIP_POLL;
        end
      end
      XIP_POLL: begin
        // Re-read CTRL until busy drops
        xip_we_o = 1'b0;
        if (wb_ack_i && !wb_dat_i[CTRL_GO_BIT]) begin
          state_next = XIP_READ;
        end
      end
      XIP_READ: begin
        // Flash data lands in the low word
        xip_adr_o = REG_RX0;
        xip_we_o  = 1'b0;
        if (wb_ack_i) begin
          state_next = XIP_RELEASE;
        end
      end
      XIP_RELEASE: begin
        xip_adr_o = REG_SS;
        if (wb_ack_i) begin
          state_next = XIP_IDLE;
        end
      end
      default: begin
        state_next = XIP_IDLE;
      end
    endcase
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state  <= XIP_IDLE;
      done_o <= 1'b0;
    end else begin
      state  <= state_next;
      done_o <= (state == XIP_RELEASE) && wb_ack_i;
    end
  end

  // Address capture on start and data capture from RX0
  always_ff @(posedge clock) begin
    if (state == XIP_IDLE && start_i) begin
      addr_q <= flash_addr_i;
    end
    if (state == XIP_READ && wb_ack_i) begin
      rdata_o <= wb_dat_i;
    end
  end

endmodule

//--- spi_top.sv
`timescale 1ns/10ps

module spi_top (
  input  logic              clock,
  input  logic              reset,
  input  spi_pkg::wb_addr_t wb_adr_i,
  input  spi_pkg::word_t    wb_dat_i,
  input  spi_pkg::strb_t    wb_sel_i,
  input  logic              wb_we_i,
  input  logic              wb_stb_i,
  input  logic              wb_cyc_i,
  output spi_pkg::word_t    wb_dat_o,
  output logic              wb_ack_o,
  output logic              wb_err_o,
  output logic              wb_int_o,
  output spi_pkg::ss_t      ss_pad_o,
  output logic              sclk_pad_o,
  output logic              mosi_pad_o,
  input  logic              miso_pad_i
);
  import spi_pkg::*;

  logic        acc;
  logic        wr;
  logic        hit_0;
  logic        hit_1;
  logic        hit_ctrl;
  logic        hit_div;
  logic        hit_ss;
  logic        hit_any;
  char_len_t   char_len;
  logic        ie;
  logic        go_q;
  div_t        divider;
  ss_t         ss;
  logic        tip;
  logic        tip_q;
  logic        last;
  logic        busy;
  logic        done;
  logic        pos_edge;
  logic        neg_edge;
  logic [1:0]  tx_we;
  logic [63:0] rx;
  word_t       ctrl_rd;

  // New access, masked in the ack cycle so a held strobe is not served twice
  assign acc = wb_stb_i && wb_cyc_i && !wb_ack_o;
  assign wr  = acc && wb_we_i;

  // Offset decode
  assign hit_0    = (wb_adr_i == REG_TX0);
  assign hit_1    = (wb_adr_i == REG_TX1);
  assign hit_ctrl = (wb_adr_i == REG_CTRL);
  assign hit_div  = (wb_adr_i == REG_DIVIDER);
  assign hit_ss   = (wb_adr_i == REG_SS);
  assign hit_any  = hit_0 || hit_1 || hit_ctrl || hit_div || hit_ss;

  // Go pulse counts as busy until the shifter takes over
  assign busy  = go_q || tip;
  assign done  = tip_q && !tip;
  // TX halves locked during a transfer
  assign tx_we = {wr && hit_1 && !busy, wr && hit_0 && !busy};

  // Registered ack and error
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      wb_ack_o <= 1'b0;
      wb_err_o <= 1'b0;
    end else begin
      wb_ack_o <= acc;
      wb_err_o <= acc && !hit_any;
    end
  end

  // CTRL, DIVIDER and SS
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      char_len <= '0;
      ie       <= 1'b0;
      go_q     <= 1'b0;
      divider  <= '1;
      ss       <= '0;
    end else begin
      go_q <= 1'b0;
      if (wr && hit_ctrl && !busy) begin
        if (wb_sel_i[0]) begin
          char_len <= wb_dat_i[6:0];
        end
        if (wb_sel_i[1]) begin
          ie   <= wb_dat_i[CTRL_IE_BIT];
          go_q <= wb_dat_i[CTRL_GO_BIT];
        end
      end
      if (wr && hit_div && !busy) begin
        if (wb_sel_i[0]) begin
          divider[7:0] <= wb_dat_i[7:0];
        end
        if (wb_sel_i[1]) begin
          divider[15:8] <= wb_dat_i[15:8];
        end
      end
      if (wr && hit_ss && wb_sel_i[0]) begin
        ss <= wb_dat_i[SS_NUM-1:0];
      end
    end
  end

  // Completion detect and interrupt
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      tip_q    <= 1'b0;
      wb_int_o <= 1'b0;
    end else begin
      tip_q <= tip;
      if (ie && done) begin
        wb_int_o <= 1'b1;
      end else if (wb_ack_o) begin
        wb_int_o <= 1'b0;
      end
    end
  end

  // CTRL readback with go shown as busy
  always_comb begin
    ctrl_rd              = '0;
    ctrl_rd[6:0]         = char_len;
    ctrl_rd[CTRL_GO_BIT] = busy;
    ctrl_rd[CTRL_IE_BIT] = ie;
  end

  // Read mux
  always_comb begin
    case (wb_adr_i)
      REG_RX0:     wb_dat_o = rx[31:0];
      REG_RX1:     wb_dat_o = rx[63:32];
      REG_CTRL:    wb_dat_o = ctrl_rd;
      REG_DIVIDER: wb_dat_o = word_t'(divider);
      REG_SS:      wb_dat_o = word_t'(ss);
      default:     wb_dat_o = '0;
    endcase
  end

  // Selects are active low at the pads
  assign ss_pad_o = ~ss;

  spi_clgen u_clgen (
    .clock      (clock),
    .reset      (reset),
    .enable_i   (tip),
    .go_i       (go_q),
    .last_clk_i (last),
    .divider_i  (divider),
    .clk_out_o  (sclk_pad_o),
    .pos_edge_o (pos_edge),
    .neg_edge_o (neg_edge)
  );

  spi_shift u_shift (
    .clock      (clock),
    .reset      (reset),
    .len_i      (char_len),
    .tx_we_i    (tx_we),
    .sel_i      (wb_sel_i),
    .data_i     (wb_dat_i),
    .go_i       (go_q),
    .pos_edge_i (pos_edge),
    .neg_edge_i (neg_edge),
    .miso_i     (miso_pad_i),
    .tip_o      (tip),
    .last_o     (last),
    .mosi_o     (mosi_pad_o),
    .rx_o       (rx)
  );

endmodule

//--- spi_shift.sv
`timescale 1ns/10ps

module spi_shift (
  input  logic               clock,
  input  logic               reset,
  input  spi_pkg::char_len_t len_i,
  input  logic [1:0]         tx_we_i,
  input  spi_pkg::strb_t     sel_i,
  input  spi_pkg::word_t     data_i,
  input  logic               go_i,
  input  logic               pos_edge_i,
  input  logic               neg_edge_i,
  input  logic               miso_i,
  output logic               tip_o,
  output logic               last_o,
  output logic               mosi_o,
  output logic [63:0]        rx_o
);
  import spi_pkg::*;

  // Shared TX/RX register
  logic [63:0] data;
  // Bits still to be sampled
  char_len_t   cnt;
  char_len_t   len_eff;
  logic [5:0]  first_idx;
  logic [5:0]  bit_idx;

  // Zero length means a full 64-bit transfer
  assign len_eff   = (len_i == '0) ? char_len_t'(64) : len_i;
  assign first_idx = 6'(len_eff - 1'b1);
  // Current bit position, MSB of the character first
  assign bit_idx   = 6'(cnt - 1'b1);

  // Transfer control and MOSI
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      tip_o  <= 1'b0;
      cnt    <= '0;
      mosi_o <= 1'b0;
    end else if (!tip_o) begin
      if (go_i) begin
        tip_o  <= 1'b1;
        cnt    <= len_eff;
        // First bit must be on the pin before the first rising edge
        mosi_o <= data[first_idx];
      end
    end else if (pos_edge_i) begin
      cnt <= cnt - 1'b1;
      // Last rising edge ends the transfer
      if (cnt == char_len_t'(1)) begin
        tip_o <= 1'b0;
      end
    end else if (neg_edge_i) begin
      mosi_o <= data[bit_idx];
    end
  end

  // Byte-lane loads when idle, MISO capture on rising strobes
  always_ff @(posedge clock) begin
    if (tip_o) begin
      if (pos_edge_i) begin
        data[bit_idx] <= miso_i;
      end
    end else begin
      for (int b = 0; b < 4; b++) begin
        if (tx_we_i[0] && sel_i[b]) begin
          data[8*b +: 8] <= data_i[8*b +: 8];
        end
        if (tx_we_i[1] && sel_i[b]) begin
          data[32+8*b +: 8] <= data_i[8*b +: 8];
        end
      end
    end
  end

  // All bits done
  assign last_o = (cnt == '0);
  assign rx_o   = data;

endmodule

//--- spi_clgen.sv
`timescale 1ns/10ps

module spi_clgen (
  input  logic          clock,
  input  logic          reset,
  input  logic          enable_i,
  input  logic          go_i,
  input  logic          last_clk_i,
  input  spi_pkg::div_t divider_i,
  output logic          clk_out_o,
  output logic          pos_edge_o,
  output logic          neg_edge_o
);
  import spi_pkg::*;

  // Half-period down counter
  div_t cnt;
  logic cnt_zero;

  assign cnt_zero = (cnt == '0);

  // Reload while idle, on go, and at every half-period boundary
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      cnt <= '1;
    end else if (!enable_i || go_i || cnt_zero) begin
      cnt <= divider_i;
    end else begin
      cnt <= cnt - 1'b1;
    end
  end

  // Serial clock, mode 0 so it idles low
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      clk_out_o <= 1'b0;
    end else if (!enable_i) begin
      clk_out_o <= 1'b0;
    end else if (cnt_zero && (!last_clk_i || clk_out_o)) begin
      // After the last bit only a falling edge is allowed
      clk_out_o <= ~clk_out_o;
    end
  end

  // Strobes lead the clock flip by one cycle
  assign pos_edge_o = enable_i && cnt_zero && !clk_out_o && !last_clk_i;
  assign neg_edge_o = enable_i && cnt_zero && clk_out_o;

endmodule

//--- spi_pkg.sv
package spi_pkg;

  // Number of slave select lines
  localparam int SS_NUM = 8;

  // Bus and register widths
  typedef logic [31:0]       word_t;
  typedef logic [4:0]        wb_addr_t;
  typedef logic [3:0]        strb_t;
  typedef logic [SS_NUM-1:0] ss_t;
  // Transfer length in bits, zero encodes 64
  typedef logic [6:0]        char_len_t;
  typedef logic [15:0]       div_t;

  // Core register offsets, RX and TX views share an offset
  localparam wb_addr_t REG_RX0     = 5'h00;
  localparam wb_addr_t REG_TX0     = 5'h00;
  localparam wb_addr_t REG_RX1     = 5'h04;
  localparam wb_addr_t REG_TX1     = 5'h04;
  localparam wb_addr_t REG_CTRL    = 5'h10;
  localparam wb_addr_t REG_DIVIDER = 5'h14;
  localparam wb_addr_t REG_SS      = 5'h18;

  // CTRL fields
  localparam int CTRL_GO_BIT = 8;
  localparam int CTRL_IE_BIT = 12;

  // APB address windows
  localparam word_t FLASH_ADDR_START = 32'h3000_0000;
  localparam word_t FLASH_ADDR_END   = 32'h3FFF_FFFF;
  localparam word_t SPI_MASTER_BASE  = 32'h1000_1000;
  localparam word_t SPI_MASTER_END   = 32'h1000_1FFF;

  // Flash read program
  localparam logic [7:0] FLASH_READ_OP = 8'h03;
  localparam div_t       XIP_DIVIDER   = 16'd1;
  localparam char_len_t  XIP_CHAR_LEN  = 7'd64;

  // XIP sequencer states, one core access each
  typedef enum logic [2:0] {
    XIP_IDLE,
    XIP_CMD,
    XIP_DIV,
    XIP_SS,
    XIP_GO,
    XIP_POLL,
    XIP_READ,
    XIP_RELEASE
  } xip_state_t;

endpackage
